// ==== mem_pkg.sv ====
`default_nettype none

package mem_pkg;

    localparam int unsigned ADDR_W = 32;
    localparam int unsigned DATA_W = 32;
    localparam int unsigned STRB_W = DATA_W / 8;

    // byte address, low two bits ignored by the memory
    typedef logic [ADDR_W-1:0] addr_t;

    typedef logic [DATA_W-1:0] data_t;

    // bit n enables byte n
    typedef logic [STRB_W-1:0] strb_t;

    // arbiter grant
    typedef enum logic [1:0] {
        ARB_IDLE = 2'd0,
        ARB_IFU  = 2'd1,
        ARB_LSU  = 2'd2
    } arb_state_e;

    // axi-lite master sequencing
    typedef enum logic [2:0] {
        AXI_IDLE = 3'd0,
        AXI_AR   = 3'd1,
        AXI_R    = 3'd2,
        AXI_AW_W = 3'd3,
        AXI_B    = 3'd4
    } axi_state_e;

endpackage

`default_nettype wire

// ==== cpu_mem_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface cpu_mem_if;

    import mem_pkg::*;

    // read request
    logic  r_valid;
    addr_t r_addr;
    logic  r_ready;
    data_t r_data;

    // write request
    logic  w_valid;
    addr_t w_addr;
    data_t w_data;
    strb_t w_strb;
    logic  w_ready;

    // arbiter side issues the granted request
    modport arb (
        output r_valid, r_addr,
        output w_valid, w_addr, w_data, w_strb,
        input  r_ready, r_data,
        input  w_ready
    );

    // master side answers with one-cycle ready pulses
    modport mst (
        input  r_valid, r_addr,
        input  w_valid, w_addr, w_data, w_strb,
        output r_ready, r_data,
        output w_ready
    );

endinterface

`default_nettype wire

// ==== axi_lite_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface axi_lite_if;

    import mem_pkg::*;

    // write address
    logic  awvalid;
    logic  awready;
    addr_t awaddr;

    // write data
    logic  wvalid;
    logic  wready;
    data_t wdata;
    strb_t wstrb;

    // write response, always okay
    logic  bvalid;
    logic  bready;

    // read address
    logic  arvalid;
    logic  arready;
    addr_t araddr;

    // read data, always okay
    logic  rvalid;
    logic  rready;
    data_t rdata;

    modport master (
        output awvalid, awaddr, wvalid, wdata, wstrb, bready,
        output arvalid, araddr, rready,
        input  awready, wready, bvalid,
        input  arready, rvalid, rdata
    );

    modport slave (
        input  awvalid, awaddr, wvalid, wdata, wstrb, bready,
        input  arvalid, araddr, rready,
        output awready, wready, bvalid,
        output arready, rvalid, rdata
    );

endinterface

`default_nettype wire

// ==== mem_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
    input  wire logic            aclk,
    input  wire logic            areset_n,

    // instruction fetch, read only
    input  wire logic            ifu_r_valid_i,
    input  wire mem_pkg::addr_t  ifu_r_addr_i,
    output      logic            ifu_r_ready_o,
    output      mem_pkg::data_t  ifu_r_data_o,

    // load/store
    input  wire logic            lsu_r_valid_i,
    input  wire mem_pkg::addr_t  lsu_r_addr_i,
    output      logic            lsu_r_ready_o,
    output      mem_pkg::data_t  lsu_r_data_o,

    input  wire logic            lsu_w_valid_i,
    input  wire mem_pkg::addr_t  lsu_w_addr_i,
    input  wire mem_pkg::data_t  lsu_w_data_i,
    input  wire mem_pkg::strb_t  lsu_w_strb_i,
    output      logic            lsu_w_ready_o,

    cpu_mem_if.arb               cpu
);

    import mem_pkg::*;

    arb_state_e state;

    logic lsu_pending;

    assign lsu_pending = lsu_r_valid_i | lsu_w_valid_i;

    // request steering, only the granted side reaches the master
    always_comb begin
        cpu.r_valid   = 1'b0;
        cpu.r_addr    = '0;
        cpu.w_valid   = 1'b0;
        cpu.w_addr    = '0;
        cpu.w_data    = '0;
        cpu.w_strb    = '0;
        ifu_r_ready_o = 1'b0;
        ifu_r_data_o  = '0;
        lsu_r_ready_o = 1'b0;
        lsu_r_data_o  = '0;
        lsu_w_ready_o = 1'b0;
        case (state)
            ARB_IFU: begin
                cpu.r_valid   = ifu_r_valid_i;
                cpu.r_addr    = ifu_r_addr_i;
                ifu_r_ready_o = cpu.r_ready;
                ifu_r_data_o  = cpu.r_data;
            end
            ARB_LSU: begin
                cpu.r_valid   = lsu_r_valid_i;
                cpu.r_addr    = lsu_r_addr_i;
                cpu.w_valid   = lsu_w_valid_i;
                cpu.w_addr    = lsu_w_addr_i;
                cpu.w_data    = lsu_w_data_i;
                cpu.w_strb    = lsu_w_strb_i;
                lsu_r_ready_o = cpu.r_ready;
                lsu_r_data_o  = cpu.r_data;
                lsu_w_ready_o = cpu.w_ready;
            end
            default: begin
            end
        endcase
    end

    // one transfer per grant, lsu wins ties
    always_ff @(posedge aclk) begin
        if (!areset_n) begin
            state <= ARB_IDLE;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (lsu_pending) begin
                        state <= ARB_LSU;
                    end else if (ifu_r_valid_i) begin
                        state <= ARB_IFU;
                    end
                end
                ARB_IFU: begin
                    if (cpu.r_ready) begin
                        // hand straight over to a waiting lsu
                        state <= lsu_pending ? ARB_LSU : ARB_IDLE;
                    end
                end
                ARB_LSU: begin
                    if (cpu.r_ready || cpu.w_ready) begin
                        state <= ARB_IDLE;
                    end
                end
                default: begin
                    state <= ARB_IDLE;
                end
            endcase
        end
    end

    lsu_one_kind_a: assert property (
        @(posedge aclk) disable iff (!areset_n)
        !(lsu_r_valid_i && lsu_w_valid_i)
    );

    // fetch completes only for a held, granted request
    ifu_ready_granted_a: assert property (
        @(posedge aclk) disable iff (!areset_n)
        ifu_r_ready_o |-> (state == ARB_IFU) && ifu_r_valid_i
    );

endmodule

`default_nettype wire

// ==== axi_lite_master.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_lite_master (
    input  wire logic  aclk,
    input  wire logic  areset_n,
    cpu_mem_if.mst     cpu,
    axi_lite_if.master axi
);

    import mem_pkg::*;

    axi_state_e state;

    // blocks a restart while the arbiter still shows the old request
    logic done_q;

    logic aw_done;
    logic w_done;

    addr_t addr_q;
    data_t wdata_q;
    strb_t wstrb_q;

    logic aw_hs;
    logic w_hs;

    assign aw_hs = axi.awvalid && axi.awready;
    assign w_hs  = axi.wvalid && axi.wready;

    assign axi.araddr  = addr_q;
    assign axi.awaddr  = addr_q;
    assign axi.wdata   = wdata_q;
    assign axi.wstrb   = wstrb_q;

    assign axi.arvalid = (state == AXI_AR);
    assign axi.awvalid = (state == AXI_AW_W) && !aw_done;
    assign axi.wvalid  = (state == AXI_AW_W) && !w_done;
    assign axi.rready  = 1'b1;
    assign axi.bready  = 1'b1;

    // response returns in the handshake cycle
    assign cpu.r_ready = (state == AXI_R) && axi.rvalid;
    assign cpu.r_data  = axi.rdata;
    assign cpu.w_ready = (state == AXI_B) && axi.bvalid;

    always_ff @(posedge aclk) begin
        if (!areset_n) begin
            state   <= AXI_IDLE;
            done_q  <= 1'b0;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state)
                AXI_IDLE: begin
                    aw_done <= 1'b0;
                    w_done  <= 1'b0;
                    if (!done_q) begin
                        if (cpu.r_valid) begin
                            state <= AXI_AR;
                        end else if (cpu.w_valid) begin
                            state <= AXI_AW_W;
                        end
                    end
                end
                AXI_AR: begin
                    if (axi.arready) begin
                        state <= AXI_R;
                    end
                end
                AXI_R: begin
                    if (axi.rvalid) begin
                        state  <= AXI_IDLE;
                        done_q <= 1'b1;
                    end
                end
                AXI_AW_W: begin
                    if (aw_hs) begin
                        aw_done <= 1'b1;
                    end
                    if (w_hs) begin
                        w_done <= 1'b1;
                    end
                    if ((aw_done || aw_hs) && (w_done || w_hs)) begin
                        state <= AXI_B;
                    end
                end
                AXI_B: begin
                    if (axi.bvalid) begin
                        state  <= AXI_IDLE;
                        done_q <= 1'b1;
                    end
                end
                default: begin
                    state <= AXI_IDLE;
                end
            endcase
        end
    end

    // request payload captured when leaving idle
    always_ff @(posedge aclk) begin
        if (state == AXI_IDLE) begin
            if (cpu.r_valid) begin
                addr_q <= cpu.r_addr;
            end else begin
                addr_q <= cpu.w_addr;
            end
            wdata_q <= cpu.w_data;
            wstrb_q <= cpu.w_strb;
        end
    end

    arvalid_held_a: assert property (
        @(posedge aclk) disable iff (!areset_n)
        axi.arvalid && !axi.arready |=> axi.arvalid
    );

endmodule

`default_nettype wire

// ==== axi_lite_sram.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_lite_sram #(
    parameter int unsigned MEM_DEPTH   = 256,
    parameter int unsigned WAIT_STATES = 2
) (
    input  wire logic aclk,
    input  wire logic areset_n,
    axi_lite_if.slave axi
);

    import mem_pkg::*;

    localparam int unsigned IDX_W = (MEM_DEPTH > 1) ? $clog2(MEM_DEPTH) : 1;
    localparam int unsigned CNT_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

    data_t mem [MEM_DEPTH];

    logic             rd_busy;
    logic             wr_busy;
    logic [CNT_W-1:0] wait_cnt;
    logic             wait_done;
    logic             idle;
    data_t            rdata_q;

    logic ar_hs;
    logic wr_hs;

    // word index, wraps at the memory depth
    function automatic logic [IDX_W-1:0] word_idx(input addr_t a);
        return IDX_W'(a[31:2] % MEM_DEPTH);
    endfunction

    assign idle      = !rd_busy && !wr_busy;
    assign wait_done = (wait_cnt == CNT_W'(WAIT_STATES));

    assign axi.arready = idle;
    assign axi.awready = idle;
    assign axi.wready  = idle;

    assign ar_hs = axi.arvalid && axi.arready;
    // aw and w always arrive together
    assign wr_hs = axi.awvalid && axi.awready && axi.wvalid && axi.wready;

    assign axi.rvalid = rd_busy && wait_done;
    assign axi.bvalid = wr_busy && wait_done;
    assign axi.rdata  = rdata_q;

    always_ff @(posedge aclk) begin
        if (!areset_n) begin
            rd_busy  <= 1'b0;
            wr_busy  <= 1'b0;
            wait_cnt <= '0;
        end else begin
            if (ar_hs) begin
                rd_busy  <= 1'b1;
                wait_cnt <= '0;
            end else if (wr_hs) begin
                wr_busy  <= 1'b1;
                wait_cnt <= '0;
            end else if (!idle && !wait_done) begin
                wait_cnt <= wait_cnt + 1'b1;
            end
            // response held until the master takes it
            if (axi.rvalid && axi.rready) begin
                rd_busy <= 1'b0;
            end
            if (axi.bvalid && axi.bready) begin
                wr_busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (ar_hs) begin
            rdata_q <= mem[word_idx(axi.araddr)];
        end
        if (wr_hs) begin
            for (int b = 0; b < 4; b++) begin
                if (axi.wstrb[b]) begin
                    mem[word_idx(axi.awaddr)][8*b +: 8] <= axi.wdata[8*b +: 8];
                end
            end
        end
    end

    aw_with_w_a: assert property (
        @(posedge aclk) disable iff (!areset_n)
        axi.awvalid |-> axi.wvalid
    );

endmodule

`default_nettype wire

// ==== mem_subsys_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_top #(
    parameter int unsigned MEM_DEPTH   = 256,
    parameter int unsigned WAIT_STATES = 2
) (
    input  wire logic            aclk,
    input  wire logic            areset_n,

    input  wire logic            ifu_r_valid_i,
    input  wire mem_pkg::addr_t  ifu_r_addr_i,
    output      logic            ifu_r_ready_o,
    output      mem_pkg::data_t  ifu_r_data_o,

    input  wire logic            lsu_r_valid_i,
    input  wire mem_pkg::addr_t  lsu_r_addr_i,
    output      logic            lsu_r_ready_o,
    output      mem_pkg::data_t  lsu_r_data_o,

    input  wire logic            lsu_w_valid_i,
    input  wire mem_pkg::addr_t  lsu_w_addr_i,
    input  wire mem_pkg::data_t  lsu_w_data_i,
    input  wire mem_pkg::strb_t  lsu_w_strb_i,
    output      logic            lsu_w_ready_o
);

    cpu_mem_if  i_cpu_if ();
    axi_lite_if i_axi_if ();

    mem_arbiter i_arbiter (
        .aclk          (aclk),
        .areset_n      (areset_n),
        .ifu_r_valid_i (ifu_r_valid_i),
        .ifu_r_addr_i  (ifu_r_addr_i),
        .ifu_r_ready_o (ifu_r_ready_o),
        .ifu_r_data_o  (ifu_r_data_o),
        .lsu_r_valid_i (lsu_r_valid_i),
        .lsu_r_addr_i  (lsu_r_addr_i),
        .lsu_r_ready_o (lsu_r_ready_o),
        .lsu_r_data_o  (lsu_r_data_o),
        .lsu_w_valid_i (lsu_w_valid_i),
        .lsu_w_addr_i  (lsu_w_addr_i),
        .lsu_w_data_i  (lsu_w_data_i),
        .lsu_w_strb_i  (lsu_w_strb_i),
        .lsu_w_ready_o (lsu_w_ready_o),
        .cpu           (i_cpu_if.arb)
    );

    axi_lite_master i_master (
        .aclk     (aclk),
        .areset_n (areset_n),
        .cpu      (i_cpu_if.mst),
        .axi      (i_axi_if.master)
    );

    axi_lite_sram #(
        .MEM_DEPTH   (MEM_DEPTH),
        .WAIT_STATES (WAIT_STATES)
    ) i_sram (
        .aclk     (aclk),
        .areset_n (areset_n),
        .axi      (i_axi_if.slave)
    );

endmodule

`default_nettype wire

// ==== tb_mem_subsys.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsys;

    import mem_pkg::*;

    localparam int unsigned CYCLES_PER_OP = 200;

    logic  aclk;
    logic  areset_n;
    logic  ifu_r_valid_i;
    addr_t ifu_r_addr_i;
    logic  ifu_r_ready_o;
    data_t ifu_r_data_o;
    logic  lsu_r_valid_i;
    addr_t lsu_r_addr_i;
    logic  lsu_r_ready_o;
    data_t lsu_r_data_o;
    logic  lsu_w_valid_i;
    addr_t lsu_w_addr_i;
    data_t lsu_w_data_i;
    strb_t lsu_w_strb_i;
    logic  lsu_w_ready_o;

    // operations as read from the data file
    string op_port [$];
    string op_kind [$];
    addr_t op_addr [$];
    data_t op_wdata [$];
    strb_t op_strb [$];
    data_t op_exp [$];
    logic  loaded;

    // reference memory, word index to word
    data_t       model [int unsigned];
    int unsigned depth;
    int unsigned wait_states;
    logic [31:0] lfsr;
    int          cyc;
    int          n_checks;
    int          n_mismatch;
    int          n_other;

    // state of the operation in flight
    logic  ifu_on;
    logic  lsu_on;
    logic  lsu_write;
    logic  ifu_fin;
    logic  lsu_fin;
    data_t ifu_data;
    data_t lsu_data;
    int    ifu_cyc;
    int    lsu_cyc;
    int    ifu_pulses;
    int    lsu_r_pulses;
    int    lsu_w_pulses;

    mem_subsys_top i_dut (
        .aclk          (aclk),
        .areset_n      (areset_n),
        .ifu_r_valid_i (ifu_r_valid_i),
        .ifu_r_addr_i  (ifu_r_addr_i),
        .ifu_r_ready_o (ifu_r_ready_o),
        .ifu_r_data_o  (ifu_r_data_o),
        .lsu_r_valid_i (lsu_r_valid_i),
        .lsu_r_addr_i  (lsu_r_addr_i),
        .lsu_r_ready_o (lsu_r_ready_o),
        .lsu_r_data_o  (lsu_r_data_o),
        .lsu_w_valid_i (lsu_w_valid_i),
        .lsu_w_addr_i  (lsu_w_addr_i),
        .lsu_w_data_i  (lsu_w_data_i),
        .lsu_w_strb_i  (lsu_w_strb_i),
        .lsu_w_ready_o (lsu_w_ready_o)
    );

    initial begin
        aclk = 1'b0;
        forever #2 aclk = ~aclk;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // two bits, one step each
    function automatic int next_gap();
        int gap;
        gap = 0;
        for (int i = 0; i < 2; i++) begin
            lfsr = lfsr_step(lfsr);
            gap = (gap << 1) | int'(lfsr[0]);
        end
        return gap;
    endfunction

    function automatic int unsigned word_index(input addr_t a);
        return {2'b00, a[31:2]} % depth;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_mismatch++;
            $display("MISMATCH %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic report_error(input string msg);
        n_other++;
        $display("ERROR: %s", msg);
    endtask

    task automatic clear_counts();
        ifu_fin      = 1'b0;
        lsu_fin      = 1'b0;
        ifu_pulses   = 0;
        lsu_r_pulses = 0;
        lsu_w_pulses = 0;
    endtask

    // ready outputs only depend on registered state, stable at the falling edge
    task automatic sample_readies();
        if (ifu_r_ready_o) begin
            ifu_pulses++;
            if (ifu_on && !ifu_fin) begin
                ifu_fin  = 1'b1;
                ifu_data = ifu_r_data_o;
                ifu_cyc  = cyc;
            end
        end
        if (lsu_r_ready_o) begin
            lsu_r_pulses++;
            if (lsu_on && !lsu_write && !lsu_fin) begin
                lsu_fin  = 1'b1;
                lsu_data = lsu_r_data_o;
                lsu_cyc  = cyc;
            end
        end
        if (lsu_w_ready_o) begin
            lsu_w_pulses++;
            if (lsu_on && lsu_write && !lsu_fin) begin
                lsu_fin = 1'b1;
                lsu_cyc = cyc;
            end
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge aclk);
            cyc++;
            sample_readies();
        end
    endtask

    task automatic expect_quiet(input int n);
        ifu_on = 1'b0;
        lsu_on = 1'b0;
        clear_counts();
        idle_cycles(n);
        check("ifu_r_ready_o pulses", ifu_pulses, 0);
        check("lsu_r_ready_o pulses", lsu_r_pulses, 0);
        check("lsu_w_ready_o pulses", lsu_w_pulses, 0);
    endtask

    task automatic load_ops();
        int    fd;
        int    code;
        string port;
        string kind;
        string rest;
        addr_t addr;
        data_t wdata;
        strb_t strb;
        data_t exp;
        fd = $fopen("mem_subsys_testdata.txt", "r");
        if (fd == 0) begin
            report_error("cannot open mem_subsys_testdata.txt");
            return;
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", port);
            if (code != 1) begin
                break;
            end
            if (port == "#") begin
                code = $fgets(rest, fd);
                continue;
            end
            code = $fscanf(fd, "%s %h %h %h %h", kind, addr, wdata, strb, exp);
            if (code != 5) begin
                report_error($sformatf("testdata line starting with %s is incomplete", port));
                break;
            end
            op_port.push_back(port);
            op_kind.push_back(kind);
            op_addr.push_back(addr);
            op_wdata.push_back(wdata);
            op_strb.push_back(strb);
            op_exp.push_back(exp);
        end
        $fclose(fd);
    endtask

    task automatic run_op(input int i);
        int unsigned widx;
        data_t       word;
        ifu_on = 1'b0;
        lsu_on = 1'b0;
        clear_counts();
        idle_cycles(next_gap());
        widx      = word_index(op_addr[i]);
        ifu_on    = (op_port[i] == "IFU") || (op_port[i] == "BOTH");
        lsu_on    = (op_port[i] == "LSU") || (op_port[i] == "BOTH");
        lsu_write = (op_kind[i] == "W");
        if ((!ifu_on && !lsu_on) || (op_kind[i] != "R" && !lsu_write)
                || (!lsu_on && lsu_write)) begin
            report_error($sformatf("line %0d has an unknown port or kind", i));
            return;
        end
        // both requests start on the same falling edge
        // idle address ports point at another word
        ifu_r_valid_i = ifu_on;
        ifu_r_addr_i  = ifu_on ? op_addr[i] : ~op_addr[i];
        lsu_r_valid_i = lsu_on && !lsu_write;
        lsu_r_addr_i  = (lsu_on && !lsu_write) ? op_addr[i] : ~op_addr[i];
        lsu_w_valid_i = lsu_on && lsu_write;
        lsu_w_addr_i  = (lsu_on && lsu_write) ? op_addr[i] : ~op_addr[i];
        lsu_w_data_i  = op_wdata[i];
        lsu_w_strb_i  = op_strb[i];
        // valid is held through the edge that ends its ready pulse
        while (ifu_r_valid_i || lsu_r_valid_i || lsu_w_valid_i) begin
            @(negedge aclk);
            cyc++;
            if (ifu_fin) begin
                ifu_r_valid_i = 1'b0;
            end
            if (lsu_fin) begin
                lsu_r_valid_i = 1'b0;
                lsu_w_valid_i = 1'b0;
            end
            sample_readies();
        end
        if (lsu_on && lsu_write) begin
            word = model.exists(widx) ? model[widx] : 'x;
            for (int b = 0; b < 4; b++) begin
                if (op_strb[i][b]) begin
                    word[8*b +: 8] = op_wdata[i][8*b +: 8];
                end
            end
            model[widx] = word;
        end
        check("ifu_r_ready_o pulses", ifu_pulses, ifu_on ? 1 : 0);
        check("lsu_r_ready_o pulses", lsu_r_pulses, (lsu_on && !lsu_write) ? 1 : 0);
        check("lsu_w_ready_o pulses", lsu_w_pulses, (lsu_on && lsu_write) ? 1 : 0);
        if (op_port[i] == "BOTH") begin
            check("lsu ready before ifu ready", 32'(lsu_cyc < ifu_cyc), 1);
        end
        if (!model.exists(widx)) begin
            report_error($sformatf("address %h is read before any write", op_addr[i]));
        end else begin
            check("testdata expected word", op_exp[i], model[widx]);
            if (ifu_on) begin
                check("ifu_r_data_o", ifu_data, model[widx]);
                check("ifu_r_data_o", ifu_data, op_exp[i]);
            end
            if (lsu_on && !lsu_write) begin
                check("lsu_r_data_o", lsu_data, model[widx]);
                check("lsu_r_data_o", lsu_data, op_exp[i]);
            end
        end
    endtask

    initial begin
        areset_n      = 1'b0;
        ifu_r_valid_i = 1'b0;
        ifu_r_addr_i  = '0;
        lsu_r_valid_i = 1'b0;
        lsu_r_addr_i  = '0;
        lsu_w_valid_i = 1'b0;
        lsu_w_addr_i  = '0;
        lsu_w_data_i  = '0;
        lsu_w_strb_i  = '0;
        ifu_on        = 1'b0;
        lsu_on        = 1'b0;
        lsu_write     = 1'b0;
        lfsr          = 32'hc486;
        cyc           = 0;
        n_checks      = 0;
        n_mismatch    = 0;
        n_other       = 0;
        loaded        = 1'b0;
        clear_counts();
        depth       = i_dut.MEM_DEPTH;
        wait_states = i_dut.WAIT_STATES;
        load_ops();
        loaded = 1'b1;
        $display("%0d operations, %0d words, %0d wait states",
                 op_port.size(), depth, wait_states);
        repeat (5) @(negedge aclk);
        areset_n = 1'b1;
        expect_quiet(4);
        for (int i = 0; i < op_port.size(); i++) begin
            run_op(i);
        end
        expect_quiet(4);
        $display("checks %0d, mismatches %0d, other errors %0d", n_checks, n_mismatch, n_other);
        if (n_mismatch == 0 && n_other == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        wait (loaded);
        repeat ((op_port.size() + 2) * CYCLES_PER_OP) @(posedge aclk);
        $display("timeout: a request got no ready pulse within %0d cycles per operation",
                 CYCLES_PER_OP);
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== mem_subsys_testdata.txt ====
# port kind address write_data strobe expected (all hex, BOTH adds an IFU read of the address)
# expected is the word at the address once the operation is done
LSU W 00000010 11223344 f 11223344
IFU R 00000010 00000000 0 11223344
LSU R 00000010 00000000 0 11223344
LSU W 00000010 aabbccdd 5 11bb33dd
LSU R 00000010 00000000 0 11bb33dd
IFU R 00000013 00000000 0 11bb33dd
LSU R 00000410 00000000 0 11bb33dd
LSU W 00000020 cafef00d f cafef00d
LSU W 00000820 00001234 3 cafe1234
IFU R 00000022 00000000 0 cafe1234
BOTH W 00000030 deadbeef f deadbeef
BOTH R 00000030 00000000 0 deadbeef
LSU W 00000040 01020304 f 01020304
LSU W 00000040 a0b0c0d0 8 a0020304
BOTH W 00000041 ffffffff 2 a002ff04
IFU R 00000c40 00000000 0 a002ff04
LSU W 00000044 55aa55aa f 55aa55aa
BOTH R 00000444 00000000 0 55aa55aa
LSU W 000003fc 89abcdef f 89abcdef
IFU R 000007fc 00000000 0 89abcdef
LSU W 000003fc 00000000 0 89abcdef
LSU R 000003ff 00000000 0 89abcdef
LSU W 00000000 0f0f0f0f f 0f0f0f0f
LSU W 00000000 f0f0f0f0 6 0ff0f00f
BOTH R 00000400 00000000 0 0ff0f00f
IFU R 00000002 00000000 0 0ff0f00f
LSU R 00000044 00000000 0 55aa55aa
IFU R 00000030 00000000 0 deadbeef
BOTH W 00000030 12345678 c 1234beef
LSU R 00000030 00000000 0 1234beef

// ==== compile.f ====
mem_pkg.sv
cpu_mem_if.sv
axi_lite_if.sv
mem_arbiter.sv
axi_lite_master.sv
axi_lite_sram.sv
mem_subsys_top.sv
tb_mem_subsys.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_mem_subsys
FILELIST  := compile.f
BUILD_DIR := obj_dir
PASS_MSG  := All tests passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
